// ==== hdl/sm83_pkg.sv ====
package sm83_pkg;

	// ********************************************************************
	// datapath widths
	// ********************************************************************

	// the accumulator and every source operand are one byte wide.
	localparam int DATA_W = 8;

	// the flag nibble is held as Z, N, H, C from the high bit down.
	localparam int FLAG_W = 4;

	// bit positions of each flag inside the nibble.
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 2;
	localparam int FLAG_H = 1;
	localparam int FLAG_C = 0;

	// the y field of the opcode selects an ALU operation, a rotate kind or a bit index.
	localparam int SEL_W = 3;
	localparam int KIND_W = 4;

	// ********************************************************************
	// operation kinds passed from decode to execute
	// ********************************************************************

	localparam logic [KIND_W-1:0] KIND_NOP = 4'd0;
	localparam logic [KIND_W-1:0] KIND_ALU = 4'd1;
	localparam logic [KIND_W-1:0] KIND_INC = 4'd2;
	localparam logic [KIND_W-1:0] KIND_DEC = 4'd3;
	localparam logic [KIND_W-1:0] KIND_CPL = 4'd4;
	localparam logic [KIND_W-1:0] KIND_DAA = 4'd5;
	localparam logic [KIND_W-1:0] KIND_SCF = 4'd6;
	localparam logic [KIND_W-1:0] KIND_CCF = 4'd7;
	// main bank rotate, where Z is always cleared.
	localparam logic [KIND_W-1:0] KIND_ROTA = 4'd8;
	// CB bank rotate or shift, where Z follows the result.
	localparam logic [KIND_W-1:0] KIND_ROTCB = 4'd9;
	localparam logic [KIND_W-1:0] KIND_BIT = 4'd10;
	localparam logic [KIND_W-1:0] KIND_RES = 4'd11;
	localparam logic [KIND_W-1:0] KIND_SET = 4'd12;

	// ALU group operations, in the order of the y field.
	localparam logic [SEL_W-1:0] ALU_ADD = 3'd0;
	localparam logic [SEL_W-1:0] ALU_ADC = 3'd1;
	localparam logic [SEL_W-1:0] ALU_SUB = 3'd2;
	localparam logic [SEL_W-1:0] ALU_SBC = 3'd3;
	localparam logic [SEL_W-1:0] ALU_AND = 3'd4;
	localparam logic [SEL_W-1:0] ALU_XOR = 3'd5;
	localparam logic [SEL_W-1:0] ALU_OR = 3'd6;
	localparam logic [SEL_W-1:0] ALU_CP = 3'd7;

	// ********************************************************************
	// opcode fields and fixed opcodes
	// ********************************************************************

	// register code 7 names A in both the z and the y field.
	localparam logic [SEL_W-1:0] REG_A_CODE = 3'd7;
	// z value of the immediate forms in the top quarter of the map.
	localparam logic [SEL_W-1:0] Z_IMM = 3'd6;

	localparam logic [1:0] MAIN_GRP_ALU = 2'd2;
	localparam logic [1:0] MAIN_GRP_IMM = 2'd3;
	localparam logic [1:0] CB_GRP_ROT = 2'd0;
	localparam logic [1:0] CB_GRP_BIT = 2'd1;
	localparam logic [1:0] CB_GRP_RES = 2'd2;
	localparam logic [1:0] CB_GRP_SET = 2'd3;

	localparam logic [DATA_W-1:0] OP_INC_A = 8'h3C;
	localparam logic [DATA_W-1:0] OP_DEC_A = 8'h3D;
	localparam logic [DATA_W-1:0] OP_CPL = 8'h2F;
	localparam logic [DATA_W-1:0] OP_DAA = 8'h27;
	localparam logic [DATA_W-1:0] OP_SCF = 8'h37;
	localparam logic [DATA_W-1:0] OP_CCF = 8'h3F;
	localparam logic [DATA_W-1:0] OP_RLCA = 8'h07;
	localparam logic [DATA_W-1:0] OP_RRCA = 8'h0F;
	localparam logic [DATA_W-1:0] OP_RLA = 8'h17;
	localparam logic [DATA_W-1:0] OP_RRA = 8'h1F;

endpackage

// ==== hdl/sm83_decode.sv ====
`timescale 1ns/100ps

module sm83_decode (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          op_valid,
	input  logic                          op_bank,
	input  logic [sm83_pkg::DATA_W-1:0]   op,
	input  logic [sm83_pkg::DATA_W-1:0]   operand,
	output logic                          exec_valid,
	output logic [sm83_pkg::KIND_W-1:0]   exec_kind,
	output logic [sm83_pkg::SEL_W-1:0]    exec_sel,
	output logic                          exec_use_a,
	output logic [sm83_pkg::DATA_W-1:0]   exec_operand
);

	import sm83_pkg::*;

	// the opcode splits into a two bit group and two three bit fields.
	logic [1:0]        grp;
	logic [SEL_W-1:0]  y;
	logic [SEL_W-1:0]  z;
	logic [KIND_W-1:0] kind;

	assign grp = op[7:6];
	assign y = op[5:3];
	assign z = op[2:0];

	// ********************************************************************
	// opcode classification
	// ********************************************************************

	always_comb begin
		kind = KIND_NOP;
		if (op_bank) begin
			// only the CB forms that act on A are kept.
			// the group alone picks rotate, BIT, RES or SET.
			if (z == REG_A_CODE) begin
				case (grp)
					CB_GRP_ROT: kind = KIND_ROTCB;
					CB_GRP_BIT: kind = KIND_BIT;
					CB_GRP_RES: kind = KIND_RES;
					CB_GRP_SET: kind = KIND_SET;
					default:    kind = KIND_NOP;
				endcase
			end
		end else if (grp == MAIN_GRP_ALU || (grp == MAIN_GRP_IMM && z == Z_IMM)) begin
			// the register forms 80 to BF and the immediate forms C6 to FE.
			// both carry the ALU operation in y, so they share one kind.
			kind = KIND_ALU;
		end else begin
			case (op)
				OP_INC_A: kind = KIND_INC;
				OP_DEC_A: kind = KIND_DEC;
				OP_CPL:   kind = KIND_CPL;
				OP_DAA:   kind = KIND_DAA;
				OP_SCF:   kind = KIND_SCF;
				OP_CCF:   kind = KIND_CCF;
				// the four accumulator rotates keep their kind in y (0 to 3).
				OP_RLCA, OP_RRCA, OP_RLA, OP_RRA: kind = KIND_ROTA;
				default:  kind = KIND_NOP;
			endcase
		end
	end

	// ********************************************************************
	// pipeline register towards the accumulator stage
	// ********************************************************************

	// the valid strobe and the kind are control state and are cleared.
	always_ff @(posedge clk) begin
		if (reset) begin
			exec_valid <= 1'b0;
			exec_kind <= KIND_NOP;
		end else begin
			exec_valid <= op_valid;
			if (op_valid) begin
				exec_kind <= kind;
			end
		end
	end

	// the selector, source choice and operand only matter with exec_valid.
	always_ff @(posedge clk) begin
		if (op_valid) begin
			exec_sel <= y;
			// a source field of 7 names A, so the operand byte is not used.
			// the CB forms kept here all have z equal to 7 as well.
			exec_use_a <= (z == REG_A_CODE);
			exec_operand <= operand;
		end
	end

	// an unknown strobe would let an undefined op into the pipeline.
	a_op_valid_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(op_valid))
		else $error("op_valid is unknown outside reset");

endmodule

// ==== hdl/sm83_alu.sv ====
`timescale 1ns/100ps

module sm83_alu (
	input  logic [sm83_pkg::KIND_W-1:0] kind,
	input  logic [sm83_pkg::SEL_W-1:0]  sel,
	input  logic [sm83_pkg::DATA_W-1:0] acc,
	input  logic [sm83_pkg::DATA_W-1:0] src,
	input  logic [sm83_pkg::FLAG_W-1:0] flags,
	output logic [sm83_pkg::DATA_W-1:0] result,
	output logic [sm83_pkg::FLAG_W-1:0] flags_next,
	output logic                        write_a
);

	import sm83_pkg::*;

	logic              cin;
	logic [DATA_W:0]   add_sum;
	logic [DATA_W:0]   sub_diff;
	logic [DATA_W-1:0] inc_res;
	logic [DATA_W-1:0] dec_res;
	logic [DATA_W-1:0] rot_res;
	logic              rot_carry;
	logic [DATA_W:0]   daa;

	// ********************************************************************
	// adders
	// ********************************************************************

	// the carry only enters ADC and SBC.
	assign cin = (sel == ALU_ADC || sel == ALU_SBC) && flags[FLAG_C];
	// bit 8 holds the carry of the sum or the borrow of the difference.
	assign add_sum = {1'b0, acc} + {1'b0, src} + {8'd0, cin};
	assign sub_diff = {1'b0, acc} - {1'b0, src} - {8'd0, cin};
	assign inc_res = acc + 8'd1;
	assign dec_res = acc - 8'd1;

	// rotate and shift on A, shared by RLCA..RRA and the CB group.
	// the main bank forms only ever reach selectors 0 to 3.
	always_comb begin
		case (sel)
			3'd0: {rot_carry, rot_res} = {acc, acc[7]};
			3'd1: {rot_res, rot_carry} = {acc[0], acc};
			3'd2: {rot_carry, rot_res} = {acc, flags[FLAG_C]};
			3'd3: {rot_res, rot_carry} = {flags[FLAG_C], acc};
			3'd4: {rot_carry, rot_res} = {acc, 1'b0};
			3'd5: {rot_res, rot_carry} = {acc[7], acc};
			// swap returns the nibbles exchanged and never a carry.
			3'd6: {rot_carry, rot_res} = {1'b0, acc[3:0], acc[7:4]};
			default: {rot_res, rot_carry} = {1'b0, acc};
		endcase
	end

	// decimal adjust after an addition or a subtraction of BCD bytes.
	// the high correction after an addition looks at the already corrected value.
	always_comb begin
		daa = {1'b0, acc};
		if (!flags[FLAG_N]) begin
			if (flags[FLAG_H] || daa[3:0] > 4'd9) begin
				daa = daa + 9'h006;
			end
			if (flags[FLAG_C] || daa > 9'h09F) begin
				daa = daa + 9'h060;
			end
		end else begin
			if (flags[FLAG_H]) begin
				daa = daa - 9'h006;
				if (!flags[FLAG_C]) begin
					daa[8] = 1'b0;
				end
			end
			if (flags[FLAG_C]) begin
				daa = daa - 9'h060;
			end
		end
	end

	// ********************************************************************
	// result and flag selection
	// ********************************************************************

	// by default A and the flags pass through unchanged and A is not written.
	always_comb begin
		result = acc;
		flags_next = flags;
		write_a = 1'b0;
		case (kind)
			KIND_ALU: begin
				// CP computes the difference only for its flags.
				write_a = (sel != ALU_CP);
				flags_next[FLAG_N] = 1'b0;
				flags_next[FLAG_H] = 1'b0;
				flags_next[FLAG_C] = 1'b0;
				case (sel)
					ALU_ADD, ALU_ADC: begin
						result = add_sum[7:0];
						flags_next[FLAG_H] = acc[4] ^ src[4] ^ add_sum[4];
						flags_next[FLAG_C] = add_sum[8];
					end
					ALU_SUB, ALU_SBC, ALU_CP: begin
						result = sub_diff[7:0];
						flags_next[FLAG_N] = 1'b1;
						flags_next[FLAG_H] = acc[4] ^ src[4] ^ sub_diff[4];
						flags_next[FLAG_C] = sub_diff[8];
					end
					ALU_AND: begin
						result = acc & src;
						flags_next[FLAG_H] = 1'b1;
					end
					ALU_XOR: result = acc ^ src;
					ALU_OR:  result = acc | src;
					default: result = acc;
				endcase
				flags_next[FLAG_Z] = (result == 8'h00);
			end
			// INC and DEC leave the carry alone.
			KIND_INC: begin
				result = inc_res;
				write_a = 1'b1;
				flags_next[FLAG_Z] = (inc_res == 8'h00);
				flags_next[FLAG_N] = 1'b0;
				flags_next[FLAG_H] = acc[4] ^ inc_res[4];
			end
			KIND_DEC: begin
				result = dec_res;
				write_a = 1'b1;
				flags_next[FLAG_Z] = (dec_res == 8'h00);
				flags_next[FLAG_N] = 1'b1;
				flags_next[FLAG_H] = acc[4] ^ dec_res[4];
			end
			KIND_CPL: begin
				result = ~acc;
				write_a = 1'b1;
				flags_next[FLAG_N] = 1'b1;
				flags_next[FLAG_H] = 1'b1;
			end
			KIND_DAA: begin
				result = daa[7:0];
				write_a = 1'b1;
				flags_next[FLAG_Z] = (daa[7:0] == 8'h00);
				flags_next[FLAG_H] = 1'b0;
				flags_next[FLAG_C] = flags[FLAG_C] | daa[8];
			end
			KIND_SCF, KIND_CCF: begin
				flags_next[FLAG_N] = 1'b0;
				flags_next[FLAG_H] = 1'b0;
				flags_next[FLAG_C] = (kind == KIND_SCF) ? 1'b1 : ~flags[FLAG_C];
			end
			KIND_ROTA, KIND_ROTCB: begin
				result = rot_res;
				write_a = 1'b1;
				flags_next[FLAG_Z] = (kind == KIND_ROTCB) && (rot_res == 8'h00);
				flags_next[FLAG_N] = 1'b0;
				flags_next[FLAG_H] = 1'b0;
				flags_next[FLAG_C] = rot_carry;
			end
			// BIT reports the inverse of the tested bit in Z.
			KIND_BIT: begin
				flags_next[FLAG_Z] = ~acc[sel];
				flags_next[FLAG_N] = 1'b0;
				flags_next[FLAG_H] = 1'b1;
			end
			KIND_RES, KIND_SET: begin
				result[sel] = (kind == KIND_SET);
				write_a = 1'b1;
			end
			default: write_a = 1'b0;
		endcase
	end

endmodule

// ==== hdl/sm83_acc_stage.sv ====
`timescale 1ns/100ps

module sm83_acc_stage (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        exec_valid,
	input  logic [sm83_pkg::KIND_W-1:0] exec_kind,
	input  logic [sm83_pkg::SEL_W-1:0]  exec_sel,
	input  logic                        exec_use_a,
	input  logic [sm83_pkg::DATA_W-1:0] exec_operand,
	output logic [sm83_pkg::DATA_W-1:0] a,
	output logic [sm83_pkg::FLAG_W-1:0] f,
	output logic                        done
);

	import sm83_pkg::*;

	logic [DATA_W-1:0] src;
	logic [DATA_W-1:0] result;
	logic [FLAG_W-1:0] flags_next;
	logic              write_a;

	// the source byte is A itself when the source field named A.
	// reading the registered A lets back to back ops see each other's result.
	assign src = exec_use_a ? a : exec_operand;

	// ********************************************************************
	// datapath
	// ********************************************************************

	sm83_alu u_alu (
		.kind       (exec_kind),
		.sel        (exec_sel),
		.acc        (a),
		.src        (src),
		.flags      (f),
		.result     (result),
		.flags_next (flags_next),
		.write_a    (write_a)
	);

	// ********************************************************************
	// accumulator, flags and completion strobe
	// ********************************************************************

	// the flags are written on every executed op, NOP included.
	// for a NOP the datapath hands back the old flags, so nothing changes.
	always_ff @(posedge clk) begin
		if (reset) begin
			a <= '0;
			f <= '0;
			done <= 1'b0;
		end else begin
			done <= exec_valid;
			if (exec_valid) begin
				if (write_a) begin
					a <= result;
				end
				f <= flags_next;
			end
		end
	end

	// SUB, SBC and CP always leave N set once they complete.
	a_sub_sets_n: assert property (@(posedge clk) disable iff (reset)
		exec_valid && exec_kind == KIND_ALU &&
		(exec_sel == ALU_SUB || exec_sel == ALU_SBC || exec_sel == ALU_CP)
		|=> f[FLAG_N])
		else $error("N flag clear after a subtraction");

endmodule

// ==== hdl/sm83_acc_top.sv ====
`timescale 1ns/100ps

module sm83_acc_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        op_valid,
	input  logic                        op_bank,
	input  logic [sm83_pkg::DATA_W-1:0] op,
	input  logic [sm83_pkg::DATA_W-1:0] operand,
	output logic [sm83_pkg::DATA_W-1:0] a,
	output logic [sm83_pkg::FLAG_W-1:0] f,
	output logic                        done
);

	import sm83_pkg::*;

	// decoded op travelling from the first stage to the second.
	logic              exec_valid;
	logic [KIND_W-1:0] exec_kind;
	logic [SEL_W-1:0]  exec_sel;
	logic              exec_use_a;
	logic [DATA_W-1:0] exec_operand;

	sm83_decode u_decode (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.op_bank      (op_bank),
		.op           (op),
		.operand      (operand),
		.exec_valid   (exec_valid),
		.exec_kind    (exec_kind),
		.exec_sel     (exec_sel),
		.exec_use_a   (exec_use_a),
		.exec_operand (exec_operand)
	);

	sm83_acc_stage u_acc (
		.clk          (clk),
		.reset        (reset),
		.exec_valid   (exec_valid),
		.exec_kind    (exec_kind),
		.exec_sel     (exec_sel),
		.exec_use_a   (exec_use_a),
		.exec_operand (exec_operand),
		.a            (a),
		.f            (f),
		.done         (done)
	);

endmodule

// ==== testbench/tb_sm83_acc.sv ====
`timescale 1ns/100ps

module tb_sm83_acc;

	import sm83_pkg::*;

	// each stimulus line holds five bytes: bank, opcode, operand, A and F.
	localparam int FIELDS = 5;
	localparam int MAX_LINES = 96;
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int DONE_TIMEOUT = 20;
	localparam logic [7:0] GAP_MARK = 8'hFE;
	localparam logic [7:0] END_MARK = 8'hFF;

	logic              clk;
	logic              reset;
	logic              op_valid;
	logic              op_bank;
	logic [DATA_W-1:0] op;
	logic [DATA_W-1:0] operand;
	logic [DATA_W-1:0] a;
	logic [FLAG_W-1:0] f;
	logic              done;

	logic [7:0] stim [0:FIELDS*MAX_LINES-1];
	// row of the stimulus file and the cycle in which each op sat on the inputs.
	int         op_row [0:MAX_LINES-1];
	int         issue_cycle [0:MAX_LINES-1];
	int         n_ops;
	int         cycle = 0;
	int         errors;
	int         timeouts;

	sm83_acc_top u_dut (
		.clk      (clk),
		.reset    (reset),
		.op_valid (op_valid),
		.op_bank  (op_bank),
		.op       (op),
		.operand  (operand),
		.a        (a),
		.f        (f),
		.done     (done)
	);

	// ********************************************************************
	// clock and edge counter
	// ********************************************************************

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// counts rising edges, so a done seen after edge k reads cycle k.
	always @(posedge clk) cycle <= cycle + 1;

	// ********************************************************************
	// helpers
	// ********************************************************************

	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] expected);
		if (got !== expected) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, expected);
		end
	endtask

	// builds the list of op rows, skipping gap markers up to the end marker.
	function automatic int index_ops();
		int row;
		int count;
		logic [7:0] tag;
		count = 0;
		for (row = 0; row < MAX_LINES; row++) begin
			tag = stim[row*FIELDS];
			if (tag === END_MARK || $isunknown(tag)) begin
				break;
			end
			if (tag !== GAP_MARK) begin
				op_row[count] = row;
				count++;
			end
		end
		return count;
	endfunction

	// samples done on falling edges, where it is stable.
	task automatic wait_for_done(output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < DONE_TIMEOUT) begin
			@(negedge clk);
			seen = (done === 1'b1);
			n++;
		end
	endtask

	// ops inside a group go out back to back, one per clock.
	// the loop always resumes just after a rising edge.
	task automatic drive_ops();
		int row;
		int k;
		int gap;
		logic [7:0] tag;
		k = 0;
		for (row = 0; row < MAX_LINES; row++) begin
			tag = stim[row*FIELDS];
			if (tag === END_MARK || $isunknown(tag)) begin
				break;
			end
			if (tag === GAP_MARK) begin
				gap = $urandom_range(3, 0);
				repeat (gap) begin
					@(posedge clk);
					#DRIVE_DELAY;
				end
			end else begin
				op_bank = tag[0];
				op = stim[row*FIELDS+1];
				operand = stim[row*FIELDS+2];
				op_valid = 1'b1;
				// the op stays on the inputs for the cycle that is running now.
				issue_cycle[k] = cycle;
				k++;
				@(posedge clk);
				#DRIVE_DELAY;
				op_valid = 1'b0;
			end
		end
	endtask

	// each done must come two cycles after its op and carry the expected A and F.
	task automatic check_ops();
		int k;
		int row;
		bit seen;
		for (k = 0; k < n_ops; k++) begin
			row = op_row[k];
			wait_for_done(seen);
			if (!seen) begin
				timeouts++;
				$display("op %0d on stimulus row %0d never raised done", k, row);
				break;
			end
			if (cycle != issue_cycle[k] + 2) begin
				errors++;
				$display("op %0d finished %0d cycles after it was issued instead of 2",
					k, cycle - issue_cycle[k]);
			end
			check_value($sformatf("a after op %0d", k), a, stim[row*FIELDS+3]);
			check_value($sformatf("f after op %0d", k), {4'h0, f}, stim[row*FIELDS+4]);
		end
	endtask

	// ********************************************************************
	// main sequence
	// ********************************************************************

	initial begin
		errors = 0;
		timeouts = 0;
		op_valid = 1'b0;
		op_bank = 1'b0;
		op = '0;
		operand = '0;
		reset = 1'b1;
		void'($urandom(80345));
		$readmemh("testbench/acc_stimulus.txt", stim);
		n_ops = index_ops();
		if (n_ops == 0) begin
			errors++;
			$display("the stimulus file holds no operations");
		end
		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		// with no op given, done stays low and A and F hold zero.
		repeat (3) begin
			@(negedge clk);
			check_value("done while idle", {7'd0, done}, 8'h00);
		end
		check_value("a after reset", a, 8'h00);
		check_value("f after reset", {4'h0, f}, 8'h00);
		@(posedge clk);
		#DRIVE_DELAY;

		fork
			drive_ops();
			check_ops();
		join

		// no stray done may follow the last op.
		if (timeouts == 0) begin
			repeat (3) begin
				@(negedge clk);
				check_value("done after last op", {7'd0, done}, 8'h00);
			end
		end

		$display("ops: %0d, errors: %0d, timeouts: %0d", n_ops, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== testbench/acc_stimulus.txt ====
// columns: bank opcode operand expected_a expected_f, all hex, F as ZNHC.
// a row starting with fe inserts 0 to 3 idle cycles, a row starting with ff ends the list.
00 C6 3A 3A 00
00 80 0C 46 02
00 C6 C0 06 01
00 CE 0F 16 02
00 8F 55 2C 00
00 90 2C 00 0C
00 D6 01 FF 07
00 DE 0F EF 06
00 A0 3C 2C 02
00 AF 77 00 08
00 F6 81 81 00
00 B8 0F 81 06
00 BF 00 81 0C
00 EE 8E 0F 00
FE 00 00 00 00
00 37 00 0F 01
00 3C 00 10 03
00 3D 00 0F 07
00 F6 F0 FF 00
00 3C 00 00 0A
00 2F 00 FF 0E
00 3F 00 FF 09
FE 00 00 00 00
00 E6 19 19 02
00 C6 28 41 02
00 27 00 47 00
00 C6 85 CC 00
00 27 00 32 01
00 D6 18 1A 06
00 27 00 14 04
00 D6 20 F4 05
00 27 00 94 05
FE 00 00 00 00
00 07 00 29 01
00 0F 00 94 01
00 3F 00 94 00
00 17 00 28 01
00 1F 00 94 00
01 07 00 29 01
01 0F 00 94 01
01 17 00 29 01
01 1F 00 94 01
01 2F 00 CA 00
01 37 00 AC 00
01 27 00 58 01
01 3F 00 2C 00
00 E6 01 00 0A
00 07 00 00 00
01 3F 00 00 08
FE 00 00 00 00
00 F6 D2 D2 00
01 7F 00 D2 02
01 6F 00 D2 0A
01 BF 00 52 0A
01 EF 00 72 0A
FE 00 00 00 00
00 00 00 72 0A
01 00 00 72 0A
00 3E 12 72 0A
00 87 00 E4 00
00 87 00 C8 01
00 8F 00 91 03
FF 00 00 00 00

// ==== files.f ====
hdl/sm83_pkg.sv
hdl/sm83_decode.sv
hdl/sm83_alu.sv
hdl/sm83_acc_stage.sv
hdl/sm83_acc_top.sv
testbench/tb_sm83_acc.sv

// ==== Makefile ====
# Verilator build and run of the accumulator pipeline testbench.

TOP = tb_sm83_acc

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"

# the run passes only when the pass message shows up in the output.
test:
	verilator --binary --assert --timing --timescale 1ns/100ps \
		--top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
